// ==== build.f ====
hw/dcache_pkg.sv
hw/array_port_if.sv
hw/mem_xfer_if.sv
hw/dcache_store.sv
hw/dcache_mem_port.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_asserts.sv
verif/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hw/dcache_pkg.sv
  - hw/array_port_if.sv
  - hw/mem_xfer_if.sv
  - hw/dcache_store.sv
  - hw/dcache_mem_port.sv
  - hw/dcache_ctrl.sv
  - hw/dcache_top.sv
  - target: test
    files:
      - verif/dcache_asserts.sv
      - verif/dcache_tb.sv

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int     CLK_NS      = 20;
    localparam int     NUM_OPS     = 63;   // 15 directed, rest random
    localparam int     MISS_CYCLES = 200;  // loose bound on one miss with write-back
    localparam longint WATCHDOG_NS = longint'(16 + NUM_OPS * MISS_CYCLES) * CLK_NS;

    logic                 cpu_clk, cpu_rstn, data_valid, data_wresp;
    logic                 dev_wrdy, dev_rrdy, dev_rvalid;
    logic [BE_BITS-1:0]   data_ren, data_wen, cpu_wen, cpu_ren;
    logic [WORD_BITS-1:0] data_addr, data_wdata, data_rdata;
    logic [WORD_BITS-1:0] cpu_waddr, cpu_wdata, cpu_raddr;
    logic [LINE_BITS-1:0] dev_rdata;

    integer               seed     = 32'h09bac77b;
    int                   errors   = 0;
    int                   rd_reqs  = 0;  // accepted read requests
    int                   wr_beats = 0;  // accepted write beats
    int                   rd_delay = 0;  // cycles to dev_rvalid, 0 when idle
    int                   resp_cnt = 0;  // response pulses seen
    logic [WORD_BITS-1:0] rd_addr;
    logic [WORD_BITS-1:0] mem_words [int unsigned];  // by word address
    logic [WORD_BITS-1:0] shadow    [int unsigned];  // expected contents

    dcache_top uut (.*);

    initial begin
        cpu_clk = 1'b0;
        forever #(CLK_NS / 2) cpu_clk = ~cpu_clk;
    end

    // fill pattern from the whole word address
    function automatic logic [WORD_BITS-1:0] init_word(input logic [31:0] a);
        return ({a[31:2], 2'b00} * 32'h9e37_79b1) ^ 32'h5ca1_ab1e;
    endfunction

    function automatic logic [WORD_BITS-1:0] memory_word(input logic [31:0] a);
        return mem_words.exists(a[31:2]) ? mem_words[a[31:2]] : init_word(a);
    endfunction

    function automatic logic [WORD_BITS-1:0] expected_word(input logic [31:0] a);
        return shadow.exists(a[31:2]) ? shadow[a[31:2]] : init_word(a);
    endfunction

    function automatic logic [WORD_BITS-1:0] merge_bytes(input logic [31:0] old_w,
        input logic [31:0] new_w, input logic [BE_BITS-1:0] be);
        logic [WORD_BITS-1:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
        errors++;
    endtask

    // bus side memory with random readiness
    always @(posedge cpu_clk) begin
        dev_wrdy   <= ($random(seed) & 3) != 0;
        dev_rrdy   <= ($random(seed) & 3) != 0;
        dev_rvalid <= 1'b0;
        if ((|cpu_wen) && dev_wrdy) begin
            assert (cpu_wen == '1)
                else report_mismatch("cpu_wen", cpu_wen, 4'hf);
            assert (cpu_wdata == expected_word(cpu_waddr))
                else report_mismatch("cpu_wdata", cpu_wdata, expected_word(cpu_waddr));
            assert (cpu_waddr[3:0] == {wr_beats[1:0], 2'b00})
                else report_mismatch("cpu_waddr", cpu_waddr[3:0], {wr_beats[1:0], 2'b00});
            mem_words[cpu_waddr[31:2]] = cpu_wdata;
            wr_beats <= wr_beats + 1;
        end
        if ((|cpu_ren) && dev_rrdy) begin
            assert (cpu_ren == '1)
                else report_mismatch("cpu_ren", cpu_ren, 4'hf);
            rd_addr  = cpu_raddr;
            rd_delay = ($random(seed) & 3) + 1;
            rd_reqs <= rd_reqs + 1;
        end else if (rd_delay > 0) begin
            rd_delay--;
            if (rd_delay == 0) begin
                dev_rvalid <= 1'b1;
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    dev_rdata[w*WORD_BITS +: WORD_BITS] <= memory_word(rd_addr + 4 * w);
                end
            end
        end
    end

    always @(posedge cpu_clk) begin
        if (data_valid || data_wresp) begin
            resp_cnt <= resp_cnt + 1;
        end
    end

    // exp_refills below zero skips the bus traffic checks
    task automatic run_op(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
        input logic [BE_BITS-1:0] be, input int exp_refills, input int exp_beats);
        int rd_start;
        int wb_start;
        int waited;
        rd_start = rd_reqs;
        wb_start = wr_beats;
        waited   = 0;
        @(posedge cpu_clk);
        data_addr  <= addr;
        data_wdata <= wdata;
        data_wen   <= wr ? be : '0;
        data_ren   <= wr ? '0 : '1;
        @(posedge cpu_clk);
        data_wen   <= '0;
        data_ren   <= '0;
        data_addr  <= ~addr;  // request already latched
        data_wdata <= ~wdata;
        do begin
            @(posedge cpu_clk);
            waited++;
        end while (!data_valid && !data_wresp && waited < MISS_CYCLES);
        if (!data_valid && !data_wresp) begin
            $display("no response to request at address %h within %0d cycles", addr, waited);
            errors++;
            return;
        end
        assert (data_wresp == wr && data_valid == !wr)
            else report_mismatch("data_wresp", data_wresp, wr);
        if (wr) begin
            shadow[addr[31:2]] = merge_bytes(expected_word(addr), wdata, be);
        end else begin
            assert (data_rdata == expected_word(addr))
                else report_mismatch("data_rdata", data_rdata, expected_word(addr));
        end
        if (exp_refills >= 0) begin
            assert (rd_reqs - rd_start == exp_refills)
                else report_mismatch("cpu_ren accepts", rd_reqs - rd_start, exp_refills);
            assert (wr_beats - wb_start == exp_beats)
                else report_mismatch("cpu_wen accepts", wr_beats - wb_start, exp_beats);
        end
    endtask

    initial begin
        int unsigned          r;
        logic [WORD_BITS-1:0] a;
        logic [BE_BITS-1:0]   be;
        cpu_rstn   = 1'b0;
        data_ren   = '0;
        data_wen   = '0;
        data_addr  = '0;
        data_wdata = '0;
        dev_wrdy   = 1'b0;
        dev_rrdy   = 1'b0;
        dev_rvalid = 1'b0;
        dev_rdata  = '0;
        repeat (16) @(posedge cpu_clk);
        assert (!data_valid)
            else report_mismatch("data_valid", data_valid, 0);
        assert (!data_wresp)
            else report_mismatch("data_wresp", data_wresp, 0);
        assert (cpu_wen == '0)
            else report_mismatch("cpu_wen", cpu_wen, 0);
        assert (cpu_ren == '0)
            else report_mismatch("cpu_ren", cpu_ren, 0);
        cpu_rstn <= 1'b1;

        // cold read, then masked store and read-back hit
        run_op(0, 32'h0000_0400, 0, 0, 1, 0);
        run_op(1, 32'h0000_0404, 32'hdead_beef, 4'b0101, 0, 0);
        run_op(0, 32'h0000_0404, 0, 0, 0, 0);
        // set 0x123 in order A B A C, B is the one dropped
        run_op(0, 32'h0000_1230, 0, 0, 1, 0);
        run_op(0, 32'h0000_3230, 0, 0, 1, 0);
        run_op(0, 32'h0000_1230, 0, 0, 0, 0);
        run_op(0, 32'h0000_5230, 0, 0, 1, 0);
        run_op(0, 32'h0000_1234, 0, 0, 0, 0);
        run_op(0, 32'h0000_3230, 0, 0, 1, 0);
        // dirty D pushed out by F, then read back
        run_op(1, 32'h0000_0a04, 32'h1357_9bdf, 4'hf, 1, 0);
        run_op(1, 32'h0000_0a0c, 32'h0246_8ace, 4'b1001, 0, 0);
        run_op(0, 32'h0000_2a00, 0, 0, 1, 0);
        run_op(0, 32'h0000_4a00, 0, 0, 1, 4);
        run_op(0, 32'h0000_0a04, 0, 0, 1, 0);
        run_op(0, 32'h0000_0a0c, 0, 0, 0, 0);
        // random mix, four tags over two sets
        for (int i = 0; i < NUM_OPS - 15; i++) begin
            r  = $random(seed);
            a  = 32'h0000_0400 + {r[1:0], 13'd0} + {r[2], 4'd0} + {r[4:3], 2'd0};
            be = (r[9:6] == 4'h0) ? 4'hf : r[9:6];
            run_op(r[5], a, $random(seed), be, -1, 0);
        end
        repeat (4) @(posedge cpu_clk);
        assert (resp_cnt == NUM_OPS)
            else report_mismatch("response pulses", resp_cnt, NUM_OPS);
        $display("errors: checks %0d, protocol %0d", errors, uut.u_asserts.fail_cnt);
        if (errors == 0 && uut.u_asserts.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all requests completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== verif/dcache_asserts.sv ====
`timescale 1ns/1ps

module dcache_asserts (
    input logic                              cpu_clk,
    input logic                              cpu_rstn,
    input logic                              data_valid,
    input logic                              data_wresp,
    input logic                              dev_wrdy,
    input logic [dcache_pkg::BE_BITS-1:0]    cpu_wen,
    input logic [dcache_pkg::WORD_BITS-1:0]  cpu_waddr,
    input logic [dcache_pkg::WORD_BITS-1:0]  cpu_wdata,
    input logic                              dev_rrdy,
    input logic [dcache_pkg::BE_BITS-1:0]    cpu_ren,
    input logic [dcache_pkg::WORD_BITS-1:0]  cpu_raddr
);

    int fail_cnt = 0;  // read by the testbench at the end

    task automatic flag_failure(input string what);
        $error("%s", what);
        fail_cnt++;
    endtask

    // write beat frozen under back-pressure
    wbeat_hold: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        ((|cpu_wen) && !dev_wrdy) |=>
            ($stable(cpu_wen) && $stable(cpu_waddr) && $stable(cpu_wdata)))
        else flag_failure("write beat changed while dev_wrdy was low");

    rreq_hold: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        ((|cpu_ren) && !dev_rrdy) |=> ($stable(cpu_ren) && $stable(cpu_raddr)))
        else flag_failure("read request changed while dev_rrdy was low");

    bus_excl: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        !((|cpu_wen) && (|cpu_ren)))
        else flag_failure("cpu_wen and cpu_ren active in the same cycle");

    raddr_aligned: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        (|cpu_ren) |-> (cpu_raddr[3:0] == 4'h0))
        else flag_failure("read request address not line aligned");

    // one single-cycle pulse of one kind per request
    one_resp: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        (data_valid || data_wresp) |-> !(data_valid && data_wresp) ##1 !(data_valid || data_wresp))
        else flag_failure("response pulse longer than one cycle or of both kinds");

endmodule

bind dcache_top dcache_asserts u_asserts (.*);

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                              cpu_clk,
    input  logic                              cpu_rstn,
    // CPU load/store port
    input  logic [dcache_pkg::BE_BITS-1:0]    data_ren,
    input  logic [dcache_pkg::WORD_BITS-1:0]  data_addr,
    output logic                              data_valid,
    output logic [dcache_pkg::WORD_BITS-1:0]  data_rdata,
    input  logic [dcache_pkg::BE_BITS-1:0]    data_wen,
    input  logic [dcache_pkg::WORD_BITS-1:0]  data_wdata,
    output logic                              data_wresp,
    // memory write channel
    input  logic                              dev_wrdy,
    output logic [dcache_pkg::BE_BITS-1:0]    cpu_wen,
    output logic [dcache_pkg::WORD_BITS-1:0]  cpu_waddr,
    output logic [dcache_pkg::WORD_BITS-1:0]  cpu_wdata,
    // memory read channel
    input  logic                              dev_rrdy,
    output logic [dcache_pkg::BE_BITS-1:0]    cpu_ren,
    output logic [dcache_pkg::WORD_BITS-1:0]  cpu_raddr,
    input  logic                              dev_rvalid,
    input  logic [dcache_pkg::LINE_BITS-1:0]  dev_rdata
);

    array_port_if arr_if ();
    mem_xfer_if   mem_if ();

    dcache_ctrl u_ctrl (
        .cpu_clk    (cpu_clk),
        .cpu_rstn   (cpu_rstn),
        .data_ren   (data_ren),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_valid (data_valid),
        .data_rdata (data_rdata),
        .data_wresp (data_wresp),
        .arr        (arr_if.ctrl),
        .mem        (mem_if.ctrl)
    );

    dcache_store u_store (
        .cpu_clk  (cpu_clk),
        .cpu_rstn (cpu_rstn),
        .arr      (arr_if.store)
    );

    dcache_mem_port u_mem_port (
        .cpu_clk    (cpu_clk),
        .cpu_rstn   (cpu_rstn),
        .dev_wrdy   (dev_wrdy),
        .cpu_wen    (cpu_wen),
        .cpu_waddr  (cpu_waddr),
        .cpu_wdata  (cpu_wdata),
        .dev_rrdy   (dev_rrdy),
        .cpu_ren    (cpu_ren),
        .cpu_raddr  (cpu_raddr),
        .dev_rvalid (dev_rvalid),
        .dev_rdata  (dev_rdata),
        .mem        (mem_if.port)
    );

endmodule

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                              cpu_clk,
    input  logic                              cpu_rstn,
    input  logic [dcache_pkg::BE_BITS-1:0]    data_ren,
    input  logic [dcache_pkg::BE_BITS-1:0]    data_wen,
    input  logic [dcache_pkg::WORD_BITS-1:0]  data_addr,
    input  logic [dcache_pkg::WORD_BITS-1:0]  data_wdata,
    output logic                              data_valid,
    output logic [dcache_pkg::WORD_BITS-1:0]  data_rdata,
    output logic                              data_wresp,
    array_port_if.ctrl                        arr,
    mem_xfer_if.ctrl                          mem
);
    import dcache_pkg::*;

    logic [1:0]           state;
    logic                 is_write;
    dcache_addr_u         req_addr;
    logic [WORD_BITS-1:0] req_wdata;
    logic [BE_BITS-1:0]   req_be;
    logic                 accept;
    logic                 lookup_hit;
    logic                 lookup_miss;

    assign accept      = (state == CS_IDLE) && ((|data_wen) || (|data_ren));
    assign lookup_hit  = (state == CS_LOOKUP) && arr.hit;
    assign lookup_miss = (state == CS_LOOKUP) && !arr.hit;

    // store lookup always runs on the latched request
    assign arr.lookup_addr  = req_addr;
    assign arr.wdata        = req_wdata;
    assign arr.be           = req_be;
    assign arr.commit       = lookup_hit;
    assign arr.commit_write = lookup_hit && is_write;
    assign arr.fill         = (state == CS_REFILL) && mem.refill_done;
    assign arr.fill_line    = mem.refill_line;

    // victim stays put until the fill, no latch needed
    assign mem.wb_req      = lookup_miss && arr.victim_dirty;
    assign mem.wb_addr     = arr.victim_addr;
    assign mem.wb_line     = arr.victim_line;
    assign mem.refill_req  = (lookup_miss && !arr.victim_dirty) ||
                             (state == CS_WB && mem.wb_done);
    assign mem.refill_addr = req_addr;

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            state      <= CS_IDLE;
            is_write   <= 1'b0;
            data_valid <= 1'b0;
            data_wresp <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            data_wresp <= 1'b0;
            case (state)
                CS_IDLE: begin
                    if (accept) begin
                        is_write <= |data_wen;  // stores win over loads
                        state    <= CS_LOOKUP;
                    end
                end
                CS_LOOKUP: begin
                    if (arr.hit) begin
                        data_valid <= !is_write;
                        data_wresp <= is_write;
                        state      <= CS_IDLE;
                    end else if (arr.victim_dirty) begin
                        state <= CS_WB;
                    end else begin
                        state <= CS_REFILL;
                    end
                end
                CS_WB: begin
                    if (mem.wb_done) state <= CS_REFILL;
                end
                CS_REFILL: begin
                    if (mem.refill_done) state <= CS_LOOKUP;  // replay, now hits
                end
                default: state <= CS_IDLE;
            endcase
        end
    end

    // request latch, CPU may move on after the accepting edge
    always_ff @(posedge cpu_clk) begin
        if (accept) begin
            req_addr.flat <= data_addr;
            req_wdata     <= data_wdata;
            req_be        <= data_wen;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (lookup_hit) begin
            data_rdata <= arr.hit_word;
        end
    end

endmodule

// ==== hw/dcache_mem_port.sv ====
`timescale 1ns/1ps

module dcache_mem_port (
    input  logic                                cpu_clk,
    input  logic                                cpu_rstn,
    input  logic                                dev_wrdy,
    output logic [dcache_pkg::BE_BITS-1:0]      cpu_wen,
    output logic [dcache_pkg::WORD_BITS-1:0]    cpu_waddr,
    output logic [dcache_pkg::WORD_BITS-1:0]    cpu_wdata,
    input  logic                                dev_rrdy,
    output logic [dcache_pkg::BE_BITS-1:0]      cpu_ren,
    output logic [dcache_pkg::WORD_BITS-1:0]    cpu_raddr,
    input  logic                                dev_rvalid,
    input  logic [dcache_pkg::LINE_BITS-1:0]    dev_rdata,
    mem_xfer_if.port                            mem
);
    import dcache_pkg::*;

    logic [1:0]               state;
    logic [WORD_SEL_BITS-1:0] beat_cnt;  // beat on the bus
    logic [WORD_SEL_BITS-1:0] beat_sel;  // beat being loaded
    logic                     last_beat;
    logic                     load_beat;
    dcache_addr_u             beat_addr;
    dcache_addr_u             line_addr;

    assign last_beat = (beat_cnt == WORDS_PER_LINE - 1);
    assign load_beat = (state == PS_IDLE && mem.wb_req) ||
                       (state == PS_WB && dev_wrdy && !last_beat);

    always_comb begin
        beat_sel                    = (state == PS_IDLE) ? '0 : beat_cnt + 1'b1;
        beat_addr                   = mem.wb_addr;
        beat_addr.fields.word_sel   = beat_sel;
        beat_addr.fields.byte_off   = '0;
        line_addr                   = mem.refill_addr;
        line_addr.fields.word_sel   = '0;
        line_addr.fields.byte_off   = '0;
    end

    // line returns straight from the bus
    assign mem.refill_done = (state == PS_RD_WAIT) && dev_rvalid;
    assign mem.refill_line = dev_rdata;

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            state       <= PS_IDLE;
            beat_cnt    <= '0;
            cpu_wen     <= '0;
            cpu_ren     <= '0;
            mem.wb_done <= 1'b0;
        end else begin
            mem.wb_done <= 1'b0;
            case (state)
                PS_IDLE: begin
                    if (mem.wb_req) begin
                        cpu_wen  <= '1;
                        beat_cnt <= '0;
                        state    <= PS_WB;
                    end else if (mem.refill_req) begin
                        cpu_ren <= '1;
                        state   <= PS_RD_REQ;
                    end
                end
                PS_WB: begin
                    if (dev_wrdy) begin  // beat accepted
                        if (last_beat) begin
                            cpu_wen     <= '0;
                            mem.wb_done <= 1'b1;
                            state       <= PS_IDLE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                PS_RD_REQ: begin
                    if (dev_rrdy) begin
                        cpu_ren <= '0;
                        state   <= PS_RD_WAIT;
                    end
                end
                PS_RD_WAIT: if (dev_rvalid) state <= PS_IDLE;
                default: state <= PS_IDLE;
            endcase
        end
    end

    // beat payload holds while dev_wrdy is low
    always_ff @(posedge cpu_clk) begin
        if (load_beat) begin
            cpu_waddr <= beat_addr.flat;
            cpu_wdata <= mem.wb_line[beat_sel*WORD_BITS +: WORD_BITS];
        end
        if (state == PS_IDLE && !mem.wb_req && mem.refill_req) begin
            cpu_raddr <= line_addr.flat;
        end
    end

endmodule

// ==== hw/dcache_store.sv ====
`timescale 1ns/1ps

module dcache_store (
    input  logic         cpu_clk,
    input  logic         cpu_rstn,
    array_port_if.store  arr
);
    import dcache_pkg::*;

    // tag and data arrays, no reset
    logic [TAG_BITS-1:0]  tag_mem  [NUM_WAYS][NUM_SETS];
    logic [LINE_BITS-1:0] data_mem [NUM_WAYS][NUM_SETS];

    // state bits, cleared at reset
    logic [NUM_SETS-1:0]  valid_bits [NUM_WAYS];
    logic [NUM_SETS-1:0]  dirty_bits [NUM_WAYS];
    logic [NUM_SETS-1:0]  lru_way;   // way to evict next in each set

    logic [INDEX_BITS-1:0]    idx;
    logic [TAG_BITS-1:0]      req_tag;
    logic [WORD_SEL_BITS-1:0] wsel;
    logic [NUM_WAYS-1:0]      way_hit;
    logic                     hit_way;
    logic                     victim_way;

    assign idx     = arr.lookup_addr.fields.index;
    assign req_tag = arr.lookup_addr.fields.tag;
    assign wsel    = arr.lookup_addr.fields.word_sel;

    // compare both ways
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_bits[w][idx] && (tag_mem[w][idx] == req_tag);
        end
    end

    assign hit_way      = way_hit[1];
    assign arr.hit      = |way_hit;
    assign arr.hit_word = data_mem[hit_way][idx][wsel*WORD_BITS +: WORD_BITS];

    // empty way first, then the least recently used one
    assign victim_way = !valid_bits[0][idx] ? 1'b0 :
                        !valid_bits[1][idx] ? 1'b1 :
                        lru_way[idx];

    assign arr.victim_dirty = valid_bits[victim_way][idx] && dirty_bits[victim_way][idx];
    assign arr.victim_line  = data_mem[victim_way][idx];

    always_comb begin
        arr.victim_addr              = '0;
        arr.victim_addr.fields.tag   = tag_mem[victim_way][idx];
        arr.victim_addr.fields.index = idx;
    end

    // line fill and byte-masked store merge
    always_ff @(posedge cpu_clk) begin
        if (arr.fill) begin
            data_mem[victim_way][idx] <= arr.fill_line;
            tag_mem[victim_way][idx]  <= req_tag;
        end else if (arr.commit_write) begin
            for (int b = 0; b < BE_BITS; b++) begin
                if (arr.be[b]) begin
                    data_mem[hit_way][idx][wsel*WORD_BITS + b*(WORD_BITS/BE_BITS)
                        +: WORD_BITS/BE_BITS] <= arr.wdata[b*(WORD_BITS/BE_BITS)
                        +: WORD_BITS/BE_BITS];
                end
            end
        end
    end

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            valid_bits <= '{default: '0};
            dirty_bits <= '{default: '0};
            lru_way    <= '0;
        end else if (arr.fill) begin
            valid_bits[victim_way][idx] <= 1'b1;
            dirty_bits[victim_way][idx] <= 1'b0;  // fresh copy of memory
        end else if (arr.commit) begin
            lru_way[idx] <= ~hit_way;             // other way becomes LRU
            if (arr.commit_write) begin
                dirty_bits[hit_way][idx] <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/mem_xfer_if.sv ====
`timescale 1ns/1ps

interface mem_xfer_if;
    import dcache_pkg::*;

    // write-back of a dirty victim
    logic                 wb_req;      // single cycle
    dcache_addr_u         wb_addr;     // held until wb_done
    logic [LINE_BITS-1:0] wb_line;
    logic                 wb_done;

    // line refill
    logic                 refill_req;  // single cycle
    dcache_addr_u         refill_addr;
    logic                 refill_done; // same cycle as dev_rvalid
    logic [LINE_BITS-1:0] refill_line;

    modport ctrl (
        output wb_req, wb_addr, wb_line, refill_req, refill_addr,
        input  wb_done, refill_done, refill_line
    );

    modport port (
        input  wb_req, wb_addr, wb_line, refill_req, refill_addr,
        output wb_done, refill_done, refill_line
    );

endinterface

// ==== hw/array_port_if.sv ====
`timescale 1ns/1ps

interface array_port_if;
    import dcache_pkg::*;

    // controller side
    dcache_addr_u           lookup_addr;  // latched request address
    logic                   commit;       // hit completes this cycle
    logic                   commit_write; // store hit, merge wdata
    logic [WORD_BITS-1:0]   wdata;
    logic [BE_BITS-1:0]     be;
    logic                   fill;
    logic [LINE_BITS-1:0]   fill_line;

    // store side, all follow lookup_addr
    logic                   hit;
    logic [WORD_BITS-1:0]   hit_word;
    logic                   victim_dirty;
    dcache_addr_u           victim_addr;  // line aligned
    logic [LINE_BITS-1:0]   victim_line;

    modport ctrl (
        output lookup_addr, commit, commit_write, wdata, be, fill, fill_line,
        input  hit, hit_word, victim_dirty, victim_addr, victim_line
    );

    modport store (
        input  lookup_addr, commit, commit_write, wdata, be, fill, fill_line,
        output hit, hit_word, victim_dirty, victim_addr, victim_line
    );

endinterface

// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry: 16 KB, 2 ways, 16-byte lines
    localparam int WORD_BITS      = 32;
    localparam int LINE_BITS      = 128;
    localparam int WORDS_PER_LINE = 4;   // also the write-back beat count
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 512;
    localparam int BYTE_OFF_BITS  = 2;
    localparam int WORD_SEL_BITS  = 2;
    localparam int INDEX_BITS     = 9;
    localparam int TAG_BITS       = 19;
    localparam int BE_BITS        = 4;

    // request controller states
    localparam logic [1:0] CS_IDLE   = 2'd0;
    localparam logic [1:0] CS_LOOKUP = 2'd1;
    localparam logic [1:0] CS_WB     = 2'd2;
    localparam logic [1:0] CS_REFILL = 2'd3;

    // bus engine states
    localparam logic [1:0] PS_IDLE    = 2'd0;
    localparam logic [1:0] PS_WB      = 2'd1;
    localparam logic [1:0] PS_RD_REQ  = 2'd2;
    localparam logic [1:0] PS_RD_WAIT = 2'd3;

    // one address word, seen flat or split into cache fields
    typedef union packed {
        logic [WORD_BITS-1:0] flat;
        struct packed {
            logic [TAG_BITS-1:0]      tag;
            logic [INDEX_BITS-1:0]    index;
            logic [WORD_SEL_BITS-1:0] word_sel;
            logic [BYTE_OFF_BITS-1:0] byte_off;
        } fields;
    } dcache_addr_u;

endpackage
